/* files.f */
hdl/frame_wr_pkg.sv
hdl/wr_port_ifs.sv
hdl/channel_sched.sv
hdl/line_fetch.sv
hdl/axi_burst_wr.sv
hdl/frame_wr_arbiter.sv
verif/tb_frame_wr.sv

/* hdl/axi_burst_wr.sv */
`default_nettype none

module axi_burst_wr (
    input  logic                                clk,
    input  logic                                rst,
    burst_if.snk                                bus,

    // write address channel
    output frame_wr_pkg::addr_t                 awaddr,
    output logic [7:0]                          awlen,
    output logic [2:0]                          awsize,
    output logic [1:0]                          awburst,
    output logic                                awvalid,
    input  logic                                awready,

    // write data channel
    output frame_wr_pkg::word_t                 wdata,
    output logic [frame_wr_pkg::STRB_W-1:0]     wstrb,
    output logic                                wlast,
    output logic                                wvalid,
    input  logic                                wready,

    // write response channel
    input  logic                                bvalid,
    output logic                                bready
);

    logic aw_done;      // address accepted for this burst
    logic w_done;       // last beat accepted
    logic aw_seen;
    logic w_seen;

    // fixed burst shape, all lanes written
    assign awlen   = frame_wr_pkg::AWLEN_FIX;
    assign awsize  = frame_wr_pkg::AWSIZE_FIX;
    assign awburst = frame_wr_pkg::BURST_INCR;
    assign wstrb   = '1;

    // address and beats pass straight through, valids are already held by the source
    assign awaddr  = bus.burst_addr;
    assign awvalid = bus.burst_valid;
    assign bus.burst_ready = awready;

    assign wdata  = bus.beat_data;
    assign wlast  = bus.beat_last;
    assign wvalid = bus.beat_valid;
    assign bus.beat_ready = wready;

    assign bus.resp_done = bvalid && bready;

    // include handshakes completing in this very cycle
    assign aw_seen = aw_done || (awvalid && awready);
    assign w_seen  = w_done || (wvalid && wready && wlast);

    // aw and w finish in either order, response is taken once both are in
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
            bready  <= 1'b0;
        end else if (bready) begin
            if (bvalid) begin
                bready <= 1'b0;
            end
        end else if (aw_seen && w_seen) begin
            bready  <= 1'b1;
            aw_done <= 1'b0;    // ready for the next burst
            w_done  <= 1'b0;
        end else begin
            aw_done <= aw_seen;
            w_done  <= w_seen;
        end
    end

endmodule

`default_nettype wire

/* hdl/channel_sched.sv */
`default_nettype none

module channel_sched (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [frame_wr_pkg::N_CH-1:0]   ch_ready,
    output logic [frame_wr_pkg::N_CH-1:0]   ch_done,
    sched_if.sched                          cmd
);

    frame_wr_pkg::sched_state_t state;
    frame_wr_pkg::ch_idx_t      ptr;        // channel whose turn it is
    frame_wr_pkg::ch_idx_t      ptr_next;

    // fixed rotation 0..N_CH-1
    assign ptr_next = (ptr == frame_wr_pkg::CH_W'(frame_wr_pkg::N_CH - 1))
                    ? '0 : ptr + 1'b1;

    assign cmd.cmd_ch = ptr;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state         <= frame_wr_pkg::ST_WAIT;
            ptr           <= '0;
            cmd.cmd_valid <= 1'b0;
            ch_done       <= '0;
        end else begin
            ch_done <= '0;  // pulses last one cycle

            case (state)
                frame_wr_pkg::ST_WAIT: begin
                    if (cmd.cmd_valid) begin
                        // hold the request until fetch side takes it
                        if (cmd.cmd_ready) begin
                            cmd.cmd_valid <= 1'b0;
                            state         <= frame_wr_pkg::ST_BUSY;
                        end
                    end else if (ch_ready[ptr]) begin
                        cmd.cmd_valid <= 1'b1;  // only the pointed channel counts
                    end
                end

                frame_wr_pkg::ST_BUSY: begin
                    if (cmd.cmd_done) begin
                        ch_done[ptr] <= 1'b1;
                        ptr          <= ptr_next;
                        state        <= frame_wr_pkg::ST_WAIT;
                    end
                end

                default: begin
                    state <= frame_wr_pkg::ST_WAIT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/frame_wr_arbiter.sv */
`default_nettype none

module frame_wr_arbiter (
    input  logic                                clk,
    input  logic                                rst,

    // line buffers
    input  logic [frame_wr_pkg::N_CH-1:0]       ch_ready,
    output logic [frame_wr_pkg::N_CH-1:0]       ch_done,
    output frame_wr_pkg::raddr_t                ch_raddr [frame_wr_pkg::N_CH],
    input  frame_wr_pkg::word_t                 ch_data  [frame_wr_pkg::N_CH],

    // axi4 write port
    output frame_wr_pkg::addr_t                 awaddr,
    output logic [7:0]                          awlen,
    output logic [2:0]                          awsize,
    output logic [1:0]                          awburst,
    output logic                                awvalid,
    input  logic                                awready,
    output frame_wr_pkg::word_t                 wdata,
    output logic [frame_wr_pkg::STRB_W-1:0]     wstrb,
    output logic                                wlast,
    output logic                                wvalid,
    input  logic                                wready,
    input  logic                                bvalid,
    output logic                                bready
);

    sched_if sched_bus ();
    burst_if burst_bus ();

    channel_sched i_channel_sched (
        .clk      (clk),
        .rst      (rst),
        .ch_ready (ch_ready),
        .ch_done  (ch_done),
        .cmd      (sched_bus)
    );

    line_fetch i_line_fetch (
        .clk      (clk),
        .rst      (rst),
        .ch_raddr (ch_raddr),
        .ch_data  (ch_data),
        .cmd      (sched_bus),
        .bus      (burst_bus)
    );

    axi_burst_wr i_axi_burst_wr (
        .clk      (clk),
        .rst      (rst),
        .bus      (burst_bus),
        .awaddr   (awaddr),
        .awlen    (awlen),
        .awsize   (awsize),
        .awburst  (awburst),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wlast    (wlast),
        .wvalid   (wvalid),
        .wready   (wready),
        .bvalid   (bvalid),
        .bready   (bready)
    );

endmodule

`default_nettype wire

/* hdl/frame_wr_pkg.sv */
`default_nettype none

package frame_wr_pkg;

    // channels and data path
    localparam int N_CH   = 4;
    localparam int DATA_W = 256;
    localparam int STRB_W = DATA_W / 8;       // byte lanes per beat

    // burst shape
    localparam int BURST_LEN = 16;
    localparam int BEAT_W    = $clog2(BURST_LEN);

    localparam logic [7:0] AWLEN_FIX  = 8'(BURST_LEN - 1);
    localparam logic [2:0] AWSIZE_FIX = 3'd5;  // 32 bytes per beat
    localparam logic [1:0] BURST_INCR = 2'b01;

    localparam int BURST_BYTES = BURST_LEN * STRB_W;  // 512
    localparam int OFFS_W      = $clog2(BURST_BYTES);

    // ddr address layout, msb first: channel | line | burst offset
    localparam int ADDR_W  = 28;
    localparam int CH_W    = $clog2(N_CH);
    localparam int LINE_W  = ADDR_W - CH_W - OFFS_W;

    // line buffer holds two lines
    localparam int RADDR_W = 5;

    typedef logic [DATA_W-1:0]  word_t;
    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [CH_W-1:0]    ch_idx_t;
    typedef logic [RADDR_W-1:0] raddr_t;
    typedef logic [LINE_W-1:0]  line_t;

    typedef enum logic {
        ST_WAIT,    // current channel has no line yet
        ST_BUSY     // burst in flight
    } sched_state_t;

endpackage

`default_nettype wire

/* hdl/line_fetch.sv */
`default_nettype none

module line_fetch (
    input  logic                    clk,
    input  logic                    rst,
    output frame_wr_pkg::raddr_t    ch_raddr [frame_wr_pkg::N_CH],
    input  frame_wr_pkg::word_t     ch_data  [frame_wr_pkg::N_CH],
    sched_if.fetch                  cmd,
    burst_if.src                    bus
);

    logic                               busy;
    frame_wr_pkg::ch_idx_t              cur_ch;     // channel of the burst in flight
    logic [frame_wr_pkg::BEAT_W-1:0]    beat_cnt;
    frame_wr_pkg::line_t                line_cnt [frame_wr_pkg::N_CH];
    logic                               cmd_fire;
    logic                               addr_fire;
    logic                               beat_fire;

    assign cmd_fire  = cmd.cmd_valid && cmd.cmd_ready;
    assign addr_fire = bus.burst_valid && bus.burst_ready;
    assign beat_fire = bus.beat_valid && bus.beat_ready;

    assign cmd.cmd_ready = !busy;   // one burst at a time
    assign cmd.cmd_done  = bus.resp_done;

    // region of the channel, then its line, then zero offset
    assign bus.burst_addr = {cur_ch, line_cnt[cur_ch], {frame_wr_pkg::OFFS_W{1'b0}}};
    assign bus.beat_data  = ch_data[cur_ch];    // buffer answers combinationally
    assign bus.beat_last  = (beat_cnt == frame_wr_pkg::BEAT_W'(frame_wr_pkg::BURST_LEN - 1));

    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            cur_ch <= cmd.cmd_ch;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy            <= 1'b0;
            bus.burst_valid <= 1'b0;
            bus.beat_valid  <= 1'b0;
            beat_cnt        <= '0;
        end else begin
            if (cmd_fire) begin
                busy            <= 1'b1;
                bus.burst_valid <= 1'b1;
                bus.beat_valid  <= 1'b1;
            end
            if (addr_fire) begin
                bus.burst_valid <= 1'b0;
            end
            if (beat_fire) begin
                beat_cnt <= beat_cnt + 1'b1;    // wraps back to 0 after the last beat
                if (bus.beat_last) begin
                    bus.beat_valid <= 1'b0;
                end
            end
            if (bus.resp_done) begin
                busy <= 1'b0;
            end
        end
    end

    // per-channel buffer pointer and line counter
    for (genvar g = 0; g < frame_wr_pkg::N_CH; g++) begin : g_ch
        logic sel;

        assign sel = (cur_ch == frame_wr_pkg::ch_idx_t'(g));

        always_ff @(posedge clk or negedge rst) begin
            if (!rst) begin
                ch_raddr[g] <= '0;
                line_cnt[g] <= '0;
            end else begin
                if (beat_fire && sel) begin
                    ch_raddr[g] <= ch_raddr[g] + 1'b1;  // wraps over both lines
                end
                if (bus.resp_done && sel) begin
                    line_cnt[g] <= line_cnt[g] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/wr_port_ifs.sv */
`default_nettype none

// command path between the rotation and the fetch logic
interface sched_if;
    logic                   cmd_valid;
    frame_wr_pkg::ch_idx_t  cmd_ch;
    logic                   cmd_ready;
    logic                   cmd_done;   // one cycle, burst acknowledged

    modport sched (
        output cmd_valid, cmd_ch,
        input  cmd_ready, cmd_done
    );

    modport fetch (
        input  cmd_valid, cmd_ch,
        output cmd_ready, cmd_done
    );
endinterface

// burst address, beat stream and response towards the axi side
interface burst_if;
    logic                   burst_valid;
    frame_wr_pkg::addr_t    burst_addr;
    logic                   burst_ready;
    logic                   beat_valid;
    frame_wr_pkg::word_t    beat_data;
    logic                   beat_last;
    logic                   beat_ready;
    logic                   resp_done;

    modport src (
        output burst_valid, burst_addr, beat_valid, beat_data, beat_last,
        input  burst_ready, beat_ready, resp_done
    );

    modport snk (
        input  burst_valid, burst_addr, beat_valid, beat_data, beat_last,
        output burst_ready, beat_ready, resp_done
    );
endinterface

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f files.f --top-module tb_frame_wr \
    --Mdir obj_dir -o tb_frame_wr > build.log 2>&1 \
    && ./obj_dir/tb_frame_wr > sim.log 2>&1 \
    || { echo "build or run error, see build.log and sim.log"; exit 1; }
grep -qx "test passed" sim.log && echo "simulation ok" \
    || { cat sim.log; exit 1; }

/* verif/tb_frame_wr.sv */
`default_nettype none

module tb_frame_wr;

    logic clk = 1'b0;
    logic rst = 1'b0;
    logic [frame_wr_pkg::N_CH-1:0] ch_ready = '0;
    logic [frame_wr_pkg::N_CH-1:0] ch_done;
    frame_wr_pkg::raddr_t ch_raddr [frame_wr_pkg::N_CH];
    frame_wr_pkg::word_t  ch_data  [frame_wr_pkg::N_CH];
    frame_wr_pkg::addr_t  awaddr;
    frame_wr_pkg::word_t  wdata;
    logic [7:0] awlen;
    logic [2:0] awsize;
    logic [1:0] awburst;
    logic [frame_wr_pkg::STRB_W-1:0] wstrb;
    logic awvalid, wvalid, wlast, bready;
    logic awready = 1'b0;
    logic wready = 1'b0;
    logic bvalid = 1'b0;

    // slave model state and logs
    integer seed = 32'hdb75_d676;
    logic [31:0] rnd;
    logic rand_mode = 1'b0;
    logic b_hs;
    int aw_n, wl_n, b_n, b_wait;
    frame_wr_pkg::addr_t   aw_q [$];
    frame_wr_pkg::word_t   w_q [$];
    logic                  last_q [$];
    frame_wr_pkg::ch_idx_t done_q [$];

    string cur_test;
    int errors = 0;
    int err_mark, pass_cnt, fail_cnt;
    int order [5];      // expected channel of each burst

    frame_wr_arbiter i_frame_wr_arbiter (.*);

    always #20 clk = ~clk;

    // line buffer word holds the channel in the top byte and the read address in the low 16 bits
    function automatic frame_wr_pkg::word_t buf_word(input int c, input int r);
        frame_wr_pkg::word_t w;
        w = '0;
        w[frame_wr_pkg::DATA_W-1 -: 8] = 8'(c);
        w[15:0] = 16'(r);
        return w;
    endfunction

    always_comb begin
        for (int c = 0; c < frame_wr_pkg::N_CH; c++) begin
            ch_data[c] = buf_word(c, int'(ch_raddr[c]));
        end
    end

    // axi slave samples at the edge and drives 2 units later
    always @(posedge clk) begin
        b_hs = bvalid && bready;
        if (!rst) begin
            aw_q.delete();
            w_q.delete();
            last_q.delete();
            done_q.delete();
            aw_n = 0;
            wl_n = 0;
            b_n = 0;
            b_wait = 0;
        end else begin
            if (awvalid && awready) begin
                aw_q.push_back(awaddr);
                aw_n++;
            end
            if (wvalid && wready) begin
                w_q.push_back(wdata);
                last_q.push_back(wlast);
                if (wlast) wl_n++;
            end
            for (int c = 0; c < frame_wr_pkg::N_CH; c++) begin
                if (ch_done[c]) done_q.push_back(frame_wr_pkg::ch_idx_t'(c));
            end
            if (b_hs) b_n++;
        end
        #2;
        rnd = $random(seed);
        awready = rand_mode ? rnd[0] : 1'b1;
        wready  = rand_mode ? rnd[1] : 1'b1;
        if (b_hs || !rst) begin
            bvalid = 1'b0;
        end else if (!bvalid && aw_n > b_n && wl_n > b_n) begin
            b_wait++;   // answer a few cycles after address and last beat
            if (b_wait == 3) begin
                bvalid = 1'b1;
                b_wait = 0;
            end
        end
    end

    task automatic check_addr(input string what, input frame_wr_pkg::addr_t exp,
                              input frame_wr_pkg::addr_t act);
        if (act !== exp) begin
            $display("error %s %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string what, input frame_wr_pkg::word_t exp,
                              input frame_wr_pkg::word_t act);
        if (act !== exp) begin
            $display("error %s %s expected %h actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_ch(input string what, input frame_wr_pkg::ch_idx_t exp,
                            input frame_wr_pkg::ch_idx_t act);
        if (act !== exp) begin
            $display("error %s %s expected %0d actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s %s expected %b actual %b", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        rst = 1'b0;
        ch_ready = '0;
        rand_mode = 1'b0;
        repeat (8) step();
        rst = 1'b1;
    endtask

    task automatic wait_aw(input int ch);
        int i;
        for (i = 0; i < 2000 && !awvalid; i++) step();
        if (!awvalid) begin
            $display("%s: no burst started on channel %0d", cur_test, ch);
            errors++;
        end
    endtask

    task automatic wait_done(input int n, input int ch);
        int i;
        for (i = 0; i < 2000 && done_q.size() < n; i++) step();
        if (done_q.size() < n) begin
            $display("%s: no line done on channel %0d, scheduler in %s", cur_test, ch,
                     i_frame_wr_arbiter.i_channel_sched.state.name());
            errors++;
        end
    endtask

    // compares the logged bursts against the address layout and buffer model
    task automatic check_bursts(input int n);
        int lines [frame_wr_pkg::N_CH];
        int c;
        int r;
        logic ok;
        lines = '{default: 0};
        ok = aw_q.size() >= n && w_q.size() >= 16 * n && done_q.size() >= n;
        check_bit("bursts logged", 1'b1, ok);
        for (int k = 0; k < n && ok; k++) begin
            c = order[k];
            check_ch("done channel", frame_wr_pkg::ch_idx_t'(c), done_q[k]);
            check_addr("awaddr", (frame_wr_pkg::addr_t'(c) << (frame_wr_pkg::ADDR_W - 2))
                                 | (frame_wr_pkg::addr_t'(lines[c]) << 9), aw_q[k]);
            for (int b = 0; b < 16; b++) begin
                r = (lines[c] * 16 + b) % 32;   // two lines per buffer
                check_word("wdata", buf_word(c, r), w_q[k * 16 + b]);
                check_bit("wlast", b == 15, last_q[k * 16 + b]);
            end
            lines[c]++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_mark = errors;
        apply_reset();
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            $display("%s ok", cur_test);
            pass_cnt++;
        end else begin
            $display("%s FAILED with %0d errors", cur_test, errors - err_mark);
            fail_cnt++;
        end
    endtask

    task automatic test_reset();
        start_test("reset_state");
        check_bit("awvalid", 1'b0, awvalid);
        check_bit("wvalid", 1'b0, wvalid);
        check_bit("bready", 1'b0, bready);
        check_bit("ch_done low", 1'b1, ch_done == '0);
        for (int c = 0; c < frame_wr_pkg::N_CH; c++) begin
            check_bit("ch_raddr zero", 1'b1, ch_raddr[c] == '0);
        end
        end_test();
    endtask

    task automatic test_single();
        start_test("single_burst");
        ch_ready = 4'b0001;
        wait_aw(0);
        check_bit("awlen 15", 1'b1, awlen == 8'd15);
        check_bit("awsize 5", 1'b1, awsize == 3'd5);
        check_bit("awburst incr", 1'b1, awburst == 2'b01);
        check_bit("wstrb all lanes", 1'b1, wstrb == '1);
        wait_done(1, 0);
        repeat (10) step();     // no second pulse may follow
        check_bit("one ch_done pulse", 1'b1, done_q.size() == 1);
        order = '{0, 0, 0, 0, 0};
        check_bursts(1);
        end_test();
    endtask

    task automatic test_rotation(input string name, input logic random_ready);
        start_test(name);
        rand_mode = random_ready;
        ch_ready = 4'b1111;
        wait_done(5, 0);
        ch_ready = '0;
        order = '{0, 1, 2, 3, 0};
        check_bursts(5);
        end_test();
    endtask

    task automatic test_strict_order();
        logic stalled;
        start_test("strict_order");
        ch_ready = 4'b0101;
        wait_done(1, 0);
        stalled = 1'b0;
        repeat (20) begin
            step();
            if (awvalid || wvalid) stalled = 1'b1;
        end
        check_bit("burst while channel 1 idle", 1'b0, stalled);
        ch_ready = 4'b0111;
        wait_done(3, 2);
        order = '{0, 1, 2, 0, 0};
        check_bursts(3);
        end_test();
    endtask

    initial begin
        test_reset();
        test_single();
        test_rotation("rotation", 1'b0);
        test_rotation("back_pressure", 1'b1);
        test_strict_order();
        $display("summary: %0d ok, %0d failing", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
